/* book_side.f */
+incdir+testbench
hdl/book_pkg.sv
hdl/bus_pkg.sv
hdl/book_wb_slave.sv
hdl/book_locate.sv
hdl/book_update.sv
hdl/book_side_top.sv
testbench/tb_book_side.sv

/* Bender.yml */
package:
  name: book_side

sources:
  - hdl/book_pkg.sv
  - hdl/bus_pkg.sv
  - hdl/book_wb_slave.sv
  - hdl/book_locate.sv
  - hdl/book_update.sv
  - hdl/book_side_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_book_side.sv

/* testbench/tb_book_vectors.svh */
// Command and readback table for the order book testbench
// Rows run in order over a bid ordered book with unique keys
`ifndef TB_BOOK_VECTORS_SVH
`define TB_BOOK_VECTORS_SVH

// Command write whose notify carries the command key
function automatic void cmd_row(input cmd_t c, input key_t k, input volume_t v,
                                input logic nfy, input volume_t nfy_vol);
  vec_t r;
  r = '0;
  r.is_wr          = 1'b1;
  r.dat.cmd.cmd    = c;
  r.dat.cmd.key    = k;
  r.dat.cmd.volume = v;
  r.exp_nfy        = '{vld: nfy, key: k, volume: nfy_vol};
  vectors.push_back(r);
endfunction

// Reads of all entries from the head and then the list size
function automatic void table_rows(input int n, input key_list_t keys, input vol_list_t vols);
  vec_t r;
  for (int i = 0; i < ENTRIES_N; i++) begin
    r = '0;
    r.adr                   = i[WB_ADDR_W-1:0];
    r.exp_word.entry.vld    = (i < n);
    r.exp_word.entry.key    = keys[i];
    r.exp_word.entry.volume = vols[i];
    vectors.push_back(r);
  end
  r = '0;
  r.adr                   = ADDR_LISTSIZE;
  r.exp_word.entry.volume = volume_t'(n);
  vectors.push_back(r);
endfunction

function automatic void load_vectors();
  // Empty after reset
  table_rows(0, '{default: 0}, '{default: 0});
  // Adds in mixed order with notify on head changes
  cmd_row(CMD_ADD, 500, 'h011, 1, 'h011);
  cmd_row(CMD_ADD, 300, 'h022, 0, 0);
  cmd_row(CMD_ADD, 700, 'h033, 1, 'h033);
  cmd_row(CMD_ADD, 400, 'h044, 0, 0);
  table_rows(4, '{700, 500, 400, 300, 0, 0, 0, 0}, '{'h033, 'h011, 'h044, 'h022, 0, 0, 0, 0});
  cmd_row(CMD_ADD, 600, 'h055, 0, 0);
  cmd_row(CMD_ADD, 200, 'h066, 0, 0);
  cmd_row(CMD_ADD, 800, 'h077, 1, 'h077);
  cmd_row(CMD_ADD, 100, 'h088, 0, 0);
  // Ninth add drops key 100 off the tail
  cmd_row(CMD_ADD, 450, 'h099, 0, 0);
  table_rows(8, '{800, 700, 600, 500, 450, 400, 300, 200},
             '{'h077, 'h033, 'h055, 'h011, 'h099, 'h044, 'h022, 'h066});
  // Below every key of a full table
  cmd_row(CMD_ADD, 50, 'h0aa, 0, 0);
  table_rows(8, '{800, 700, 600, 500, 450, 400, 300, 200},
             '{'h077, 'h033, 'h055, 'h011, 'h099, 'h044, 'h022, 'h066});
  // Middle delete closes the gap
  cmd_row(CMD_DELETE, 600, 0, 0, 0);
  table_rows(7, '{800, 700, 500, 450, 400, 300, 200, 0},
             '{'h077, 'h033, 'h011, 'h099, 'h044, 'h022, 'h066, 0});
  // Head delete reports the removed volume and a miss changes nothing
  cmd_row(CMD_DELETE, 800, 0, 1, 'h077);
  cmd_row(CMD_DELETE, 999, 0, 0, 0);
  table_rows(6, '{700, 500, 450, 400, 300, 200, 0, 0},
             '{'h033, 'h011, 'h099, 'h044, 'h022, 'h066, 0, 0});
  // Head, non-head and absent replace
  cmd_row(CMD_REPLACE, 700, 'h123, 1, 'h123);
  cmd_row(CMD_REPLACE, 400, 'h456, 0, 0);
  cmd_row(CMD_REPLACE, 650, 'h789, 0, 0);
  table_rows(6, '{700, 500, 450, 400, 300, 200, 0, 0},
             '{'h123, 'h011, 'h099, 'h456, 'h022, 'h066, 0, 0});
  // Only the first clear sees a valid head
  // Clear notify reports zero whatever the command volume
  cmd_row(CMD_CLEAR, 900, 'h3c5, 1, 0);
  table_rows(0, '{default: 0}, '{default: 0});
  cmd_row(CMD_CLEAR, 900, 'h3c5, 0, 0);
  table_rows(0, '{default: 0}, '{default: 0});
endfunction

`endif

/* testbench/tb_book_side.sv */
// Testbench for the bid side order book
// Runs a table of Wishbone commands and reads, checking readback words,
// list size and head notify
`default_nettype none

module tb_book_side
  import book_pkg::*;
  import bus_pkg::*;
();

  localparam int ACK_TIMEOUT = 16;

  // One stimulus row, a write with its notify or a read with its word
  typedef struct packed {
    logic                 is_wr;
    logic [WB_ADDR_W-1:0] adr;
    wb_word_u             dat;
    wb_word_u             exp_word;
    book_notify_t         exp_nfy;
  } vec_t;

  typedef key_t    key_list_t [ENTRIES_N];
  typedef volume_t vol_list_t [ENTRIES_N];

  logic         clk;
  logic         rst_n;
  wb_req_t      wb_req;
  logic         wb_ack;
  wb_word_u     wb_dat;
  book_notify_t notify;
  vec_t         vectors [$];

  `include "tb_book_vectors.svh"

  book_side_top UUT (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_wb     (wb_req),
    .o_wb_ack (wb_ack),
    .o_wb_dat (wb_dat),
    .o_notify (notify)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_entry(input wb_word_u got, input wb_word_u exp, input int adr);
    logic bad;
    // Key and volume of an empty entry are don't care
    if (exp.entry.vld)
      bad = (got !== exp);
    else
      bad = (got.entry.vld !== 1'b0);
    if (bad)
      fail_run($sformatf("[ERROR] %0t: entry %0d read %h, expected %h", $time, adr, got, exp));
  endtask

  task automatic check_notify(input book_notify_t got, input book_notify_t exp);
    logic bad;
    bad = (got.vld !== exp.vld);
    if (exp.vld)
      bad = bad | (got.key !== exp.key) | (got.volume !== exp.volume);
    if (bad)
      fail_run($sformatf("[ERROR] %0t: notify %h, expected %h", $time, got, exp));
  endtask

  task automatic check_listsize(input listsize_t got, input listsize_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: list size %0d, expected %0d", $time, got, exp));
  endtask

  // Falling edge sampling, DUT outputs are settled there
  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (wb_ack !== 1'b1 && n < ACK_TIMEOUT);
    if (wb_ack !== 1'b1)
      fail_run("no Wishbone acknowledge received");
  endtask

  // Drop the strobe after ack, then idle a random 0 to 3 cycles
  task automatic end_cycle();
    int gap;
    @(posedge clk);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    gap = $urandom % 4;
    repeat (gap) @(posedge clk);
  endtask

  task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input wb_word_u dat,
                          output book_notify_t nfy);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_ack();
    nfy = notify;
    end_cycle();
  endtask

  task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output wb_word_u dat,
                         output book_notify_t nfy);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
    wait_ack();
    dat = wb_dat;
    nfy = notify;
    end_cycle();
  endtask

  initial begin
    vec_t         v;
    wb_word_u     rd_word;
    book_notify_t nfy;
    clk    = 1'b0;
    rst_n  = 1'b0;
    wb_req = '0;
    void'($urandom(32'hf90b));
    load_vectors();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (vectors[i]) begin
      v = vectors[i];
      if (v.is_wr) begin
        wb_write(v.adr, v.dat, nfy);
      end else begin
        wb_read(v.adr, rd_word, nfy);
        // List size comes back in the volume field
        if (v.adr == ADDR_LISTSIZE)
          check_listsize(listsize_t'(rd_word.entry.volume), listsize_t'(v.exp_word.entry.volume));
        else
          check_entry(rd_word, v.exp_word, v.adr);
      end
      // Reads expect notify low
      check_notify(nfy, v.exp_nfy);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/book_side_top.sv */
// Order book side, bid ordered
// Wishbone slave in front of the key search and the table update
`default_nettype none

module book_side_top
  import book_pkg::*;
  import bus_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_rst_n,
  input  wire wb_req_t i_wb,
  output logic         o_wb_ack,
  output wb_word_u     o_wb_dat,
  output book_notify_t o_notify
);

  book_cmd_t    cmd;
  book_table_t  table_cur;
  listsize_t    listsize;
  book_locate_t loc;

  // Bus front end
  book_wb_slave u_slave (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wb       (i_wb),
    .i_table    (table_cur),
    .i_listsize (listsize),
    .o_wb_ack   (o_wb_ack),
    .o_wb_dat   (o_wb_dat),
    .o_cmd      (cmd)
  );

  // Combinational search on the current table
  book_locate u_locate (
    .i_cmd   (cmd),
    .i_table (table_cur),
    .o_loc   (loc)
  );

  // State, commits at the edge raising ack
  book_update u_update (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cmd      (cmd),
    .i_loc      (loc),
    .o_table    (table_cur),
    .o_listsize (listsize),
    .o_notify   (o_notify)
  );

endmodule

`default_nettype wire

/* hdl/book_update.sv */
// Order book table state and update
// Holds the sorted entries and list size, applies one command per cycle
// by insert and neighbour shifts, and reports head changes
`default_nettype none

module book_update
  import book_pkg::*;
(
  input  wire logic         i_clk,
  input  wire logic         i_rst_n,
  input  wire book_cmd_t    i_cmd,
  input  wire book_locate_t i_loc,
  output book_table_t       o_table,
  output listsize_t         o_listsize,
  output book_notify_t      o_notify
);

  logic [ENTRIES_N-1:0] vld_q;
  key_t                 key_q [ENTRIES_N];
  volume_t              vol_q [ENTRIES_N];
  listsize_t            listsize_q;
  listsize_t            listsize_nxt;
  book_table_t          tbl_cur;
  book_table_t          tbl_nxt;
  book_table_t          tbl_from_right;
  book_table_t          tbl_from_left;
  logic                 op_clr;
  logic                 op_add;
  logic                 op_del;
  logic                 op_rep;
  logic                 nfy_clr;
  logic                 nfy_add;
  logic                 nfy_del;
  logic                 nfy_rep;
  logic                 nfy_vld;
  volume_t              nfy_volume;
  logic                 notify_vld_q;
  key_t                 notify_key_q;
  volume_t              notify_vol_q;

  // Operation decode, qualified by the command strobe
  assign op_clr = i_cmd.vld & (i_cmd.cmd == CMD_CLEAR);
  assign op_add = i_cmd.vld & (i_cmd.cmd == CMD_ADD);
  assign op_del = i_cmd.vld & (i_cmd.cmd == CMD_DELETE);
  assign op_rep = i_cmd.vld & (i_cmd.cmd == CMD_REPLACE);

  // Current table view
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      tbl_cur[i].vld    = vld_q[i];
      tbl_cur[i].key    = key_q[i];
      tbl_cur[i].volume = vol_q[i];
    end
  end

  // Neighbour views, entry i sees i-1 or i+1
  // Shifted-in ends are empty entries
  assign tbl_from_right = tbl_cur << $bits(book_entry_t);
  assign tbl_from_left  = tbl_cur >> $bits(book_entry_t);

  // Retain, insert, take-right or take-left per entry
  always_comb begin
    tbl_nxt = tbl_cur;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (op_clr) begin
        tbl_nxt[i].vld = 1'b0;
      end else if (op_add && i_loc.insert_sel[i]) begin
        tbl_nxt[i] = '{vld: 1'b1, key: i_cmd.key, volume: i_cmd.volume};
      end else if (op_add && i_loc.shift_right[i]) begin
        // Old tail drops off when full
        tbl_nxt[i] = tbl_from_right[i];
      end else if (op_del && i_loc.shift_left[i]) begin
        tbl_nxt[i] = tbl_from_left[i];
      end else if (op_rep && i_loc.match_sel[i]) begin
        tbl_nxt[i].volume = i_cmd.volume;
      end
    end
  end

  // List size saturates at ENTRIES_N since a full add does not count
  always_comb begin
    if (op_clr) begin
      listsize_nxt = '0;
    end else if (op_add && !i_loc.full) begin
      listsize_nxt = listsize_q + 1'b1;
    end else if (op_del && i_loc.hit) begin
      listsize_nxt = listsize_q - 1'b1;
    end else begin
      listsize_nxt = listsize_q;
    end
  end

  // Head change sources
  assign nfy_clr = op_clr & tbl_cur[0].vld;
  assign nfy_add = op_add & i_loc.insert_sel[0];
  assign nfy_del = op_del & i_loc.match_sel[0];
  assign nfy_rep = op_rep & i_loc.match_sel[0];
  assign nfy_vld = nfy_clr | nfy_add | nfy_del | nfy_rep;

  // New volume for add and replace, removed head volume for delete
  // Clear reports zero
  assign nfy_volume = ({VOLUME_BITS{nfy_add | nfy_rep}} & i_cmd.volume)
                    | ({VOLUME_BITS{nfy_del}} & tbl_cur[0].volume);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vld_q        <= '0;
      listsize_q   <= '0;
      notify_vld_q <= 1'b0;
    end else begin
      for (int i = 0; i < ENTRIES_N; i++) begin
        vld_q[i] <= tbl_nxt[i].vld;
      end
      listsize_q   <= listsize_nxt;
      notify_vld_q <= nfy_vld;
    end
  end

  // Payload only moves on a command
  always_ff @(posedge i_clk) begin
    if (i_cmd.vld) begin
      for (int i = 0; i < ENTRIES_N; i++) begin
        key_q[i] <= tbl_nxt[i].key;
        vol_q[i] <= tbl_nxt[i].volume;
      end
    end
    if (nfy_vld) begin
      notify_key_q <= i_cmd.key;
      notify_vol_q <= nfy_volume;
    end
  end

  assign o_table    = tbl_cur;
  assign o_listsize = listsize_q;
  assign o_notify   = '{vld: notify_vld_q, key: notify_key_q, volume: notify_vol_q};

endmodule

`default_nettype wire

/* hdl/book_locate.sv */
// Order book key search
// Finds the matching entry and the sorted insertion point for the command
// key, and derives the shift masks used by the table update
`default_nettype none

module book_locate
  import book_pkg::*;
(
  input  wire book_cmd_t   i_cmd,
  input  wire book_table_t i_table,
  output book_locate_t     o_loc
);

  logic [ENTRIES_N-1:0] vld;
  logic [ENTRIES_N-1:0] match_sel;
  logic [ENTRIES_N-1:0] ge_mask;
  logic [ENTRIES_N-1:0] ge_inc;
  logic [ENTRIES_N-1:0] insert_sel;
  logic [ENTRIES_N-1:0] insert_tail;
  logic [ENTRIES_N-1:0] match_tail;

  // Per entry compare against the command key
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      vld[i]       = i_table[i].vld;
      // Keys are unique, so at most one bit set
      match_sel[i] = i_table[i].vld & (i_table[i].key == i_cmd.key);
      // Bid order, so this is a run of ones from the head
      ge_mask[i]   = i_table[i].vld & (i_table[i].key >= i_cmd.key);
    end
  end

  // First zero of the unary mask from the head
  // All ones means full with the key below every entry, no insert
  assign ge_inc     = ge_mask + 1'b1;
  assign insert_sel = ~ge_mask & ge_inc;

  // Inclusive toward-tail masks
  //   sel  0 0 0 0 1 0 0 0
  //   tail 1 1 1 1 1 0 0 0
  // A zero select gives an all zero mask
  assign insert_tail = ~(insert_sel - 1'b1);
  assign match_tail  = ~(match_sel - 1'b1);

  always_comb begin
    o_loc.match_sel   = match_sel;
    o_loc.hit         = |match_sel;
    o_loc.full        = &vld;
    o_loc.insert_sel  = insert_sel;
    // Beyond the insertion point each entry moves one toward the tail
    o_loc.shift_right = insert_tail & ~insert_sel;
    // From the hit onward each entry takes its tail-side neighbour
    o_loc.shift_left  = match_tail;
  end

endmodule

`default_nettype wire

/* hdl/book_wb_slave.sv */
// Wishbone classic slave for the order book
// Turns write cycles into book commands and serves entry and list size reads
`default_nettype none

module book_wb_slave
  import book_pkg::*;
  import bus_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_rst_n,
  input  wire wb_req_t     i_wb,
  input  wire book_table_t i_table,
  input  wire listsize_t   i_listsize,
  output logic             o_wb_ack,
  output wb_word_u         o_wb_dat,
  output book_cmd_t        o_cmd
);

  logic        ack_q;
  logic        new_req;
  book_entry_t rd_entry;
  wb_word_u    rd_word;
  wb_word_u    dat_q;

  // New request while ack is low, so one transfer per two cycles at most
  assign new_req = i_wb.cyc & i_wb.stb & ~ack_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= new_req;
    end
  end

  // Any write address is a command
  always_comb begin
    o_cmd.vld    = new_req & i_wb.we;
    o_cmd.cmd    = i_wb.dat.cmd.cmd;
    o_cmd.key    = i_wb.dat.cmd.key;
    o_cmd.volume = i_wb.dat.cmd.volume;
  end

  // Entry picked by the low address bits
  assign rd_entry = i_table[i_wb.adr[ENTRY_IDX_W-1:0]];

  // Read mux, unmapped addresses give zero
  always_comb begin
    rd_word = '0;
    if (i_wb.adr < WB_ADDR_W'(ENTRIES_N)) begin
      rd_word.entry.vld    = rd_entry.vld;
      rd_word.entry.key    = rd_entry.key;
      rd_word.entry.volume = rd_entry.volume;
    end else if (i_wb.adr == ADDR_LISTSIZE) begin
      // List size sits in the volume field
      rd_word.entry.volume = volume_t'(i_listsize);
    end
  end

  // Captured at the edge raising ack, held until the next read
  always_ff @(posedge i_clk) begin
    if (new_req && !i_wb.we) begin
      dat_q <= rd_word;
    end
  end

  assign o_wb_ack = ack_q;
  assign o_wb_dat = dat_q;

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
// Wishbone bus definitions
// Widths, address map, request record and the two views of the data word
`default_nettype none

package bus_pkg;

  localparam int WB_ADDR_W = 4;
  localparam int WB_DATA_W = 32;

  // Addresses 0 to 7 read entries
  localparam logic [WB_ADDR_W-1:0] ADDR_LISTSIZE = 4'd8;

  // Write view, a book command
  typedef struct packed {
    book_pkg::cmd_t    cmd;
    logic [1:0]        pad;
    book_pkg::key_t    key;
    book_pkg::volume_t volume;
  } wb_cmd_word_t;

  // Read view, one table entry
  typedef struct packed {
    logic              vld;
    logic [2:0]        pad;
    book_pkg::key_t    key;
    book_pkg::volume_t volume;
  } wb_entry_word_t;

  // Same 32 bits decoded by direction
  typedef union packed {
    wb_cmd_word_t   cmd;
    wb_entry_word_t entry;
  } wb_word_u;

  // Master side of a classic cycle
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    wb_word_u             dat;
  } wb_req_t;

endpackage

`default_nettype wire

/* hdl/book_pkg.sv */
// Order book side definitions
// Table geometry, command encoding, entry and table types, and the
// locate and notify records shared by the book datapath
`default_nettype none

package book_pkg;

  // Table geometry
  localparam int ENTRIES_N   = 8;
  localparam int ENTRY_IDX_W = $clog2(ENTRIES_N);
  localparam int KEY_BITS    = 16;
  localparam int VOLUME_BITS = 12;
  // Wide enough to hold ENTRIES_N itself
  localparam int LISTSIZE_W  = 4;

  typedef logic [KEY_BITS-1:0]    key_t;
  typedef logic [VOLUME_BITS-1:0] volume_t;
  typedef logic [LISTSIZE_W-1:0]  listsize_t;

  // Book commands
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Command as issued by the bus slave
  typedef struct packed {
    logic    vld;
    cmd_t    cmd;
    key_t    key;
    volume_t volume;
  } book_cmd_t;

  // One price level
  typedef struct packed {
    logic    vld;
    key_t    key;
    volume_t volume;
  } book_entry_t;

  // Entry 0 is the head, highest key
  typedef book_entry_t [ENTRIES_N-1:0] book_table_t;

  // Search result over the current table
  typedef struct packed {
    logic [ENTRIES_N-1:0] match_sel;
    logic                 hit;
    logic                 full;
    logic [ENTRIES_N-1:0] insert_sel;
    // Positions taking entry i-1 on ADD
    logic [ENTRIES_N-1:0] shift_right;
    // Positions taking entry i+1 on DELETE
    logic [ENTRIES_N-1:0] shift_left;
  } book_locate_t;

  // Head change report
  typedef struct packed {
    logic    vld;
    key_t    key;
    volume_t volume;
  } book_notify_t;

endpackage

`default_nettype wire
